/* Makefile */
VERILATOR  := verilator
FLIST      := flist.f
TOP        := riscv_mw_tb
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
SIM_ARGS   := +verilator+error+limit+100
PASS_MSG   := TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

/* flist.f */
verilog/riscv_isa_pkg.sv
verilog/riscv_pipe_pkg.sv
verilog/riscv_load_unit.sv
verilog/riscv_ppreg_mw.sv
verilog/riscv_wb_select.sv
verilog/riscv_regfile.sv
verilog/riscv_instret_counter.sv
verilog/riscv_mw_top.sv
test/riscv_mw_checker.sv
test/riscv_mw_tb.sv

/* test/riscv_mw_checker.sv */
`default_nettype none

module riscv_mw_checker (
    input logic                      i_riscv_mw_clk,
    input logic                      i_riscv_mw_rst,
    input logic                      i_riscv_mw_en,
    input logic                      i_riscv_mw_flush,
    input riscv_pipe_pkg::wb_stage_t i_riscv_mw_wb
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WB_W = $bits(riscv_pipe_pkg::wb_stage_t);

    logic [WB_W-2:0] body;
    int unsigned     fail_cnt;   // failed assertion count

    initial fail_cnt = 0;

    assign body = i_riscv_mw_wb[WB_W-1:1];   // instret is bit 0

    a_flush_clears: assert property (@(posedge i_riscv_mw_clk) disable iff (i_riscv_mw_rst)
        i_riscv_mw_flush |=> (i_riscv_mw_wb == '0))
        else begin
            fail_cnt++;
            $error("flush left a nonzero writeback bundle");
        end

    a_stall_no_retire: assert property (@(posedge i_riscv_mw_clk) disable iff (i_riscv_mw_rst)
        i_riscv_mw_en |=> !i_riscv_mw_wb.instret)
        else begin
            fail_cnt++;
            $error("instret high after a stalled edge");
        end

    a_stall_holds: assert property (@(posedge i_riscv_mw_clk) disable iff (i_riscv_mw_rst)
        (i_riscv_mw_en && !i_riscv_mw_flush) |=> $stable(body))
        else begin
            fail_cnt++;
            $error("writeback bundle changed under stall");
        end

endmodule

bind riscv_ppreg_mw riscv_mw_checker u_checker (
    .i_riscv_mw_clk   (i_riscv_mw_clk),
    .i_riscv_mw_rst   (i_riscv_mw_rst),
    .i_riscv_mw_en    (i_riscv_mw_en),
    .i_riscv_mw_flush (i_riscv_mw_flush),
    .i_riscv_mw_wb    (o_riscv_mw_wb)
);

`default_nettype wire

/* test/riscv_mw_tb.sv */
`default_nettype none

module riscv_mw_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN    = riscv_isa_pkg::XLEN;
    localparam int TIMEOUT = 50;   // poll steps of 2 ns

    typedef struct {
        string                      name;
        logic                       stall;
        logic                       flush;
        riscv_pipe_pkg::mem_stage_t mem;
        logic [XLEN-1:0]            bus;
        logic [4:0]                 rdaddr;
        riscv_pipe_pkg::wb_stage_t  exp_wb;
        riscv_pipe_pkg::rf_write_t  exp_rfw;
        logic [XLEN-1:0]            exp_rd;
        logic [XLEN-1:0]            exp_rd2;   // second port reads ~rdaddr
        logic [63:0]                exp_cnt;
    } step_t;

    logic                       clk;
    logic                       rst;
    logic                       stall;
    logic                       flush;
    riscv_pipe_pkg::mem_stage_t mem_in;
    logic [XLEN-1:0]            bus_in;
    logic [4:0]                 rs1addr;
    logic [4:0]                 rs2addr;
    riscv_pipe_pkg::wb_stage_t  wb_out;
    riscv_pipe_pkg::rf_write_t  rfw_out;
    logic [XLEN-1:0]            rs1data;
    logic [XLEN-1:0]            rs2data;
    logic [63:0]                count;

    step_t                      steps[$];
    integer                     seed;
    riscv_pipe_pkg::wb_stage_t  m_wb;       // reference model state
    logic [XLEN-1:0]            m_regs[32];
    logic [63:0]                m_cnt;

    riscv_mw_top #(
        .NUM_REGS (32),
        .CNT_W    (64)
    ) u_dut (
        .i_riscv_mw_clk         (clk),
        .i_riscv_mw_rst         (rst),
        .i_riscv_mw_en          (stall),
        .i_riscv_mw_flush       (flush),
        .i_riscv_mw_mem         (mem_in),
        .i_riscv_mw_busdata     (bus_in),
        .i_riscv_mw_rs1addr     (rs1addr),
        .i_riscv_mw_rs2addr     (rs2addr),
        .o_riscv_mw_wb          (wb_out),
        .o_riscv_mw_rfw         (rfw_out),
        .o_riscv_mw_rs1data     (rs1data),
        .o_riscv_mw_rs2data     (rs2data),
        .o_riscv_mw_instret_cnt (count)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic wait_fall(string what);
        int polls;
        polls = 0;
        while (clk !== 1'b1 && polls < TIMEOUT) begin
            #2;
            polls++;
        end
        while (clk !== 1'b0 && polls < TIMEOUT) begin
            #2;
            polls++;
        end
        if (polls >= TIMEOUT) begin
            abort_run($sformatf("clock stopped toggling while waiting in %s", what));
        end
    endtask

    task automatic check_wb(string name, riscv_pipe_pkg::wb_stage_t exp,
                            riscv_pipe_pkg::wb_stage_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s wb: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_rfw(string name, riscv_pipe_pkg::rf_write_t exp,
                             riscv_pipe_pkg::rf_write_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s rfw: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_assertions(string name);
        if (u_dut.u_ppreg_mw.u_checker.fail_cnt != 0) begin
            abort_run($sformatf("pipeline register assertion failed by step %s", name));
        end
    endtask

    function automatic logic [XLEN-1:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // byte lane picked by offset, then extended per funct3
    function automatic logic [XLEN-1:0] load_value(logic [XLEN-1:0] bus, logic [2:0] off,
                                                   logic [2:0] f3);
        logic [XLEN-1:0] w;
        w = bus >> (8 * int'(off));
        case (f3)
            3'd0: return XLEN'($signed(w[7:0]));
            3'd1: return XLEN'($signed(w[15:0]));
            3'd2: return XLEN'($signed(w[31:0]));
            3'd3: return w;
            3'd4: return XLEN'(w[7:0]);
            3'd5: return XLEN'(w[15:0]);
            3'd6: return XLEN'(w[31:0]);
            default: return '0;
        endcase
    endfunction

    function automatic riscv_pipe_pkg::rf_write_t write_of(riscv_pipe_pkg::wb_stage_t wb);
        riscv_pipe_pkg::rf_write_t w;
        w.we    = wb.regw && !wb.gototrap && (wb.rdaddr != 5'd0);
        w.waddr = wb.rdaddr;
        case (wb.resultsrc)
            3'd0: w.wdata = wb.result;
            3'd1: w.wdata = wb.memload;
            3'd2: w.wdata = wb.pcplus4;
            3'd3: w.wdata = wb.uimm;
            3'd4: w.wdata = wb.csrout;
            3'd5: w.wdata = wb.rddata_sc;
            default: w.wdata = '0;
        endcase
        return w;
    endfunction

    function automatic riscv_pipe_pkg::mem_stage_t rand_mem(logic [2:0] src, logic [2:0] f3,
                                                           logic [2:0] off, logic [4:0] rd,
                                                           logic regw);
        riscv_pipe_pkg::mem_stage_t m;
        m = '0;
        {m.pc, m.rs2data, m.pcplus4, m.result} = {rand64(), rand64(), rand64(), rand64()};
        {m.uimm, m.csrout, m.rddata_sc} = {rand64(), rand64(), rand64()};
        m.addr_lo   = off;
        m.funct3    = riscv_isa_pkg::load_size_e'(f3);
        m.rdaddr    = rd;
        m.resultsrc = riscv_isa_pkg::result_src_e'(src);
        m.regw      = regw;
        m.iscsr     = (src == 3'd4);
        m.instret   = 1'b1;
        return m;
    endfunction

    // one clock edge of the model, then record what the DUT must show
    task automatic add_step(string name, logic st, logic fl, riscv_pipe_pkg::mem_stage_t m,
                            logic [XLEN-1:0] bus, logic [4:0] rd);
        step_t                     s;
        riscv_pipe_pkg::rf_write_t w;
        riscv_pipe_pkg::wb_stage_t cand;
        w = write_of(m_wb);
        if (w.we) begin
            m_regs[w.waddr] = w.wdata;
        end
        m_cnt = m_cnt + {63'd0, m_wb.instret};
        cand = {m.pc, m.rs2data, m.pcplus4, m.result, m.uimm, m.csrout, m.rddata_sc,
                load_value(bus, m.addr_lo, m.funct3), m.rdaddr, m.resultsrc, m.regw,
                m.iscsr, m.gototrap, m.returnfromtrap, m.instret};
        if (fl) begin
            m_wb = '0;
        end else if (!st) begin
            m_wb = cand;
        end else begin
            m_wb.instret = 1'b0;
        end
        s = '{name: name, stall: st, flush: fl, mem: m, bus: bus, rdaddr: rd, exp_wb: m_wb,
              exp_rfw: write_of(m_wb), exp_rd: m_regs[rd], exp_rd2: m_regs[~rd],
              exp_cnt: m_cnt};
        steps.push_back(s);
    endtask

    task automatic build_steps();
        logic [4:0]                 rd;
        logic [4:0]                 prev_rd;
        logic [31:0]                r;
        riscv_pipe_pkg::mem_stage_t m;
        prev_rd = 5'd0;
        for (int f = 0; f < 8; f++) begin
            for (int off = 0; off < 8; off++) begin
                rd = 5'(1 + (f * 8 + off) % 31);
                m = rand_mem(3'd1, 3'(f), 3'(off), rd, 1'b1);
                add_step($sformatf("load f3=%0d off=%0d", f, off), 1'b0, 1'b0, m, rand64(),
                         prev_rd);   // previous target is visible now
                prev_rd = rd;
            end
        end
        for (int src = 0; src < 8; src++) begin
            rd = 5'(src + 10);
            add_step($sformatf("resultsrc %0d", src), 1'b0, 1'b0,
                     rand_mem(3'(src), 3'd3, 3'd0, rd, 1'b1), rand64(), prev_rd);
            prev_rd = rd;
        end
        add_step("write x0", 1'b0, 1'b0, rand_mem(3'd0, 3'd3, 3'd0, 5'd0, 1'b1), rand64(), prev_rd);
        add_step("read x0", 1'b0, 1'b0, rand_mem(3'd0, 3'd3, 3'd0, 5'd1, 1'b0), rand64(), 5'd0);
        add_step("stall head", 1'b0, 1'b0, rand_mem(3'd0, 3'd3, 3'd0, 5'd20, 1'b1), rand64(),
                 5'd20);
        for (int n = 0; n < 3; n++) begin
            add_step($sformatf("stall %0d", n), 1'b1, 1'b0,
                     rand_mem(3'd2, 3'd3, 3'd0, 5'd21, 1'b1), rand64(), 5'd20);
        end
        add_step("stall release", 1'b0, 1'b0, rand_mem(3'd0, 3'd3, 3'd0, 5'd22, 1'b0),
                 rand64(), 5'd21);
        add_step("flush", 1'b0, 1'b1, rand_mem(3'd0, 3'd3, 3'd0, 5'd23, 1'b1), rand64(), 5'd23);
        add_step("after flush", 1'b0, 1'b0, rand_mem(3'd0, 3'd3, 3'd0, 5'd2, 1'b0), rand64(),
                 5'd23);
        m = rand_mem(3'd0, 3'd3, 3'd0, 5'd24, 1'b1);
        m.gototrap       = 1'b1;
        m.returnfromtrap = riscv_isa_pkg::RET_M;
        add_step("trap", 1'b0, 1'b0, m, rand64(), 5'd24);
        add_step("after trap", 1'b0, 1'b0, rand_mem(3'd0, 3'd3, 3'd0, 5'd3, 1'b0), rand64(),
                 5'd24);
        for (int n = 0; n < 40; n++) begin
            r = $random(seed);
            m = rand_mem(r[2:0], r[5:3], r[8:6], r[13:9], r[14]);
            m.gototrap       = (r[17:15] == 3'd0);
            m.returnfromtrap = r[18] ? riscv_isa_pkg::RET_S : riscv_isa_pkg::RET_NONE;
            add_step($sformatf("random %0d", n), r[21:20] == 2'd0, r[24:22] == 3'd0, m,
                     rand64(), r[29:25]);
        end
    endtask

    initial begin
        seed       = 60092;
        rst        = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        mem_in     = '0;
        bus_in     = '0;
        rs1addr    = 5'd31;
        rs2addr    = 5'd0;
        m_wb       = '0;
        m_cnt      = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        build_steps();
        #1;
        repeat (3) wait_fall("reset");
        rst = 1'b0;
        check_wb("reset", '0, wb_out);
        check_rfw("reset", '0, rfw_out);
        check_word("reset rs1", '0, rs1data);
        check_word("reset rs2", '0, rs2data);
        check_word("reset count", '0, count);
        foreach (steps[i]) begin
            stall   = steps[i].stall;
            flush   = steps[i].flush;
            mem_in  = steps[i].mem;
            bus_in  = steps[i].bus;
            rs1addr = steps[i].rdaddr;
            rs2addr = ~steps[i].rdaddr;
            wait_fall(steps[i].name);
            check_wb(steps[i].name, steps[i].exp_wb, wb_out);
            check_rfw(steps[i].name, steps[i].exp_rfw, rfw_out);
            check_word({steps[i].name, " rs1"}, steps[i].exp_rd, rs1data);
            check_word({steps[i].name, " rs2"}, steps[i].exp_rd2, rs2data);
            check_word({steps[i].name, " count"}, steps[i].exp_cnt, count);
            check_assertions(steps[i].name);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/riscv_instret_counter.sv */
`default_nettype none

module riscv_instret_counter #(
    parameter int CNT_W = 64
) (
    input  logic             i_riscv_mw_clk,
    input  logic             i_riscv_mw_rst,
    input  logic             i_riscv_mw_instret,
    output logic [CNT_W-1:0] o_riscv_mw_count
);

    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst) begin
        if (i_riscv_mw_rst) begin
            o_riscv_mw_count <= '0;
        end else if (i_riscv_mw_instret) begin
            o_riscv_mw_count <= o_riscv_mw_count + CNT_W'(1);   // wraps
        end
    end

endmodule

`default_nettype wire

/* verilog/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

    parameter int XLEN       = 64;
    parameter int REG_ADDR_W = 5;

    // writeback value source, 6 and 7 unused
    typedef enum logic [2:0] {
        RES_ALU  = 3'd0,
        RES_LOAD = 3'd1,
        RES_PC4  = 3'd2,
        RES_UIMM = 3'd3,
        RES_CSR  = 3'd4,
        RES_SC   = 3'd5
    } result_src_e;

    // load funct3 encodings
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LD  = 3'd3,
        LBU = 3'd4,
        LHU = 3'd5,
        LWU = 3'd6
    } load_size_e;

    // xret kind carried down from the CSR stage
    typedef enum logic [1:0] {
        RET_NONE = 2'd0,
        RET_S    = 2'd1,
        RET_M    = 2'd2
    } trap_ret_e;

endpackage

`default_nettype wire

/* verilog/riscv_load_unit.sv */
`default_nettype none

module riscv_load_unit (
    input  logic [riscv_isa_pkg::XLEN-1:0] i_riscv_mw_busdata,
    input  logic [2:0]                     i_riscv_mw_addr_lo,
    input  riscv_isa_pkg::load_size_e      i_riscv_mw_funct3,
    output logic [riscv_isa_pkg::XLEN-1:0] o_riscv_mw_memload
);

    localparam int XLEN = riscv_isa_pkg::XLEN;

    logic [XLEN-1:0] shifted;

    // bring the addressed byte down to bit 0
    assign shifted = i_riscv_mw_busdata >> {i_riscv_mw_addr_lo, 3'b000};

    always_comb begin
        case (i_riscv_mw_funct3)
            riscv_isa_pkg::LB: begin
                o_riscv_mw_memload = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            end
            riscv_isa_pkg::LH: begin
                o_riscv_mw_memload = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            end
            riscv_isa_pkg::LW: begin
                o_riscv_mw_memload = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
            end
            riscv_isa_pkg::LD: begin
                o_riscv_mw_memload = shifted;
            end
            riscv_isa_pkg::LBU: begin
                o_riscv_mw_memload = {{(XLEN-8){1'b0}}, shifted[7:0]};
            end
            riscv_isa_pkg::LHU: begin
                o_riscv_mw_memload = {{(XLEN-16){1'b0}}, shifted[15:0]};
            end
            riscv_isa_pkg::LWU: begin
                o_riscv_mw_memload = {{(XLEN-32){1'b0}}, shifted[31:0]};
            end
            default: begin
                o_riscv_mw_memload = '0;   // funct3 7 is not a load
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/riscv_mw_top.sv */
`default_nettype none

module riscv_mw_top #(
    parameter int NUM_REGS = 32,
    parameter int CNT_W    = 64
) (
    input  logic                                 i_riscv_mw_clk,
    input  logic                                 i_riscv_mw_rst,
    input  logic                                 i_riscv_mw_en,
    input  logic                                 i_riscv_mw_flush,
    input  riscv_pipe_pkg::mem_stage_t           i_riscv_mw_mem,
    input  logic [riscv_isa_pkg::XLEN-1:0]       i_riscv_mw_busdata,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] i_riscv_mw_rs1addr,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] i_riscv_mw_rs2addr,
    output riscv_pipe_pkg::wb_stage_t            o_riscv_mw_wb,
    output riscv_pipe_pkg::rf_write_t            o_riscv_mw_rfw,
    output logic [riscv_isa_pkg::XLEN-1:0]       o_riscv_mw_rs1data,
    output logic [riscv_isa_pkg::XLEN-1:0]       o_riscv_mw_rs2data,
    output logic [CNT_W-1:0]                     o_riscv_mw_instret_cnt
);

    logic [riscv_isa_pkg::XLEN-1:0] memload;
    riscv_pipe_pkg::wb_stage_t      wb_next;

    riscv_load_unit u_load_unit (
        .i_riscv_mw_busdata (i_riscv_mw_busdata),
        .i_riscv_mw_addr_lo (i_riscv_mw_mem.addr_lo),
        .i_riscv_mw_funct3  (i_riscv_mw_mem.funct3),
        .o_riscv_mw_memload (memload)
    );

    // offset and funct3 are consumed here, the loaded value takes their place
    assign wb_next = '{
        pc:             i_riscv_mw_mem.pc,
        rs2data:        i_riscv_mw_mem.rs2data,
        pcplus4:        i_riscv_mw_mem.pcplus4,
        result:         i_riscv_mw_mem.result,
        uimm:           i_riscv_mw_mem.uimm,
        csrout:         i_riscv_mw_mem.csrout,
        rddata_sc:      i_riscv_mw_mem.rddata_sc,
        memload:        memload,
        rdaddr:         i_riscv_mw_mem.rdaddr,
        resultsrc:      i_riscv_mw_mem.resultsrc,
        regw:           i_riscv_mw_mem.regw,
        iscsr:          i_riscv_mw_mem.iscsr,
        gototrap:       i_riscv_mw_mem.gototrap,
        returnfromtrap: i_riscv_mw_mem.returnfromtrap,
        instret:        i_riscv_mw_mem.instret
    };

    riscv_ppreg_mw u_ppreg_mw (
        .i_riscv_mw_clk     (i_riscv_mw_clk),
        .i_riscv_mw_rst     (i_riscv_mw_rst),
        .i_riscv_mw_en      (i_riscv_mw_en),
        .i_riscv_mw_flush   (i_riscv_mw_flush),
        .i_riscv_mw_wb_next (wb_next),
        .o_riscv_mw_wb      (o_riscv_mw_wb)
    );

    riscv_wb_select u_wb_select (
        .i_riscv_mw_wb  (o_riscv_mw_wb),
        .o_riscv_mw_rfw (o_riscv_mw_rfw)
    );

    riscv_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .i_riscv_mw_clk     (i_riscv_mw_clk),
        .i_riscv_mw_rst     (i_riscv_mw_rst),
        .i_riscv_mw_rfw     (o_riscv_mw_rfw),
        .i_riscv_mw_rs1addr (i_riscv_mw_rs1addr),
        .i_riscv_mw_rs2addr (i_riscv_mw_rs2addr),
        .o_riscv_mw_rs1data (o_riscv_mw_rs1data),
        .o_riscv_mw_rs2data (o_riscv_mw_rs2data)
    );

    riscv_instret_counter #(
        .CNT_W (CNT_W)
    ) u_instret_counter (
        .i_riscv_mw_clk     (i_riscv_mw_clk),
        .i_riscv_mw_rst     (i_riscv_mw_rst),
        .i_riscv_mw_instret (o_riscv_mw_wb.instret),
        .o_riscv_mw_count   (o_riscv_mw_instret_cnt)
    );

endmodule

`default_nettype wire

/* verilog/riscv_pipe_pkg.sv */
`default_nettype none

package riscv_pipe_pkg;

    // bundle leaving the memory stage
    typedef struct packed {
        logic [riscv_isa_pkg::XLEN-1:0]       pc;
        logic [riscv_isa_pkg::XLEN-1:0]       rs2data;
        logic [riscv_isa_pkg::XLEN-1:0]       pcplus4;
        logic [riscv_isa_pkg::XLEN-1:0]       result;
        logic [riscv_isa_pkg::XLEN-1:0]       uimm;
        logic [riscv_isa_pkg::XLEN-1:0]       csrout;
        logic [riscv_isa_pkg::XLEN-1:0]       rddata_sc;
        logic [2:0]                           addr_lo;   // byte offset in bus word
        riscv_isa_pkg::load_size_e            funct3;
        logic [riscv_isa_pkg::REG_ADDR_W-1:0] rdaddr;
        riscv_isa_pkg::result_src_e           resultsrc;
        logic                                 regw;
        logic                                 iscsr;
        logic                                 gototrap;
        riscv_isa_pkg::trap_ret_e             returnfromtrap;
        logic                                 instret;
    } mem_stage_t;

    // registered writeback bundle
    typedef struct packed {
        logic [riscv_isa_pkg::XLEN-1:0]       pc;
        logic [riscv_isa_pkg::XLEN-1:0]       rs2data;
        logic [riscv_isa_pkg::XLEN-1:0]       pcplus4;
        logic [riscv_isa_pkg::XLEN-1:0]       result;
        logic [riscv_isa_pkg::XLEN-1:0]       uimm;
        logic [riscv_isa_pkg::XLEN-1:0]       csrout;
        logic [riscv_isa_pkg::XLEN-1:0]       rddata_sc;
        logic [riscv_isa_pkg::XLEN-1:0]       memload;   // aligned, extended
        logic [riscv_isa_pkg::REG_ADDR_W-1:0] rdaddr;
        riscv_isa_pkg::result_src_e           resultsrc;
        logic                                 regw;
        logic                                 iscsr;
        logic                                 gototrap;
        riscv_isa_pkg::trap_ret_e             returnfromtrap;
        logic                                 instret;
    } wb_stage_t;

    typedef struct packed {
        logic                                 we;
        logic [riscv_isa_pkg::REG_ADDR_W-1:0] waddr;
        logic [riscv_isa_pkg::XLEN-1:0]       wdata;
    } rf_write_t;

endpackage

`default_nettype wire

/* verilog/riscv_ppreg_mw.sv */
`default_nettype none

module riscv_ppreg_mw (
    input  logic                      i_riscv_mw_clk,
    input  logic                      i_riscv_mw_rst,
    input  logic                      i_riscv_mw_en,      // stall
    input  logic                      i_riscv_mw_flush,
    input  riscv_pipe_pkg::wb_stage_t i_riscv_mw_wb_next,
    output riscv_pipe_pkg::wb_stage_t o_riscv_mw_wb
);

    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst) begin
        if (i_riscv_mw_rst) begin
            o_riscv_mw_wb <= '0;
        end else if (i_riscv_mw_flush) begin
            o_riscv_mw_wb <= '0;   // bubble, nothing retires
        end else if (!i_riscv_mw_en) begin
            o_riscv_mw_wb <= i_riscv_mw_wb_next;
        end else begin
            // hold the bundle, a stalled instruction retires once
            o_riscv_mw_wb.instret <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/riscv_regfile.sv */
`default_nettype none

module riscv_regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic                                 i_riscv_mw_clk,
    input  logic                                 i_riscv_mw_rst,
    input  riscv_pipe_pkg::rf_write_t            i_riscv_mw_rfw,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] i_riscv_mw_rs1addr,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0] i_riscv_mw_rs2addr,
    output logic [riscv_isa_pkg::XLEN-1:0]       o_riscv_mw_rs1data,
    output logic [riscv_isa_pkg::XLEN-1:0]       o_riscv_mw_rs2data
);

    logic [riscv_isa_pkg::XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge i_riscv_mw_clk or posedge i_riscv_mw_rst) begin
        if (i_riscv_mw_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_riscv_mw_rfw.we && (i_riscv_mw_rfw.waddr != '0)) begin
            regs[i_riscv_mw_rfw.waddr] <= i_riscv_mw_rfw.wdata;   // x0 stays zero
        end
    end

    // no bypass, same-cycle write shows next cycle
    assign o_riscv_mw_rs1data = regs[i_riscv_mw_rs1addr];
    assign o_riscv_mw_rs2data = regs[i_riscv_mw_rs2addr];

endmodule

`default_nettype wire

/* verilog/riscv_wb_select.sv */
`default_nettype none

module riscv_wb_select (
    input  riscv_pipe_pkg::wb_stage_t i_riscv_mw_wb,
    output riscv_pipe_pkg::rf_write_t o_riscv_mw_rfw
);

    logic [riscv_isa_pkg::XLEN-1:0] wdata;

    always_comb begin
        case (i_riscv_mw_wb.resultsrc)
            riscv_isa_pkg::RES_ALU: begin
                wdata = i_riscv_mw_wb.result;
            end
            riscv_isa_pkg::RES_LOAD: begin
                wdata = i_riscv_mw_wb.memload;
            end
            riscv_isa_pkg::RES_PC4: begin
                wdata = i_riscv_mw_wb.pcplus4;   // jal / jalr link
            end
            riscv_isa_pkg::RES_UIMM: begin
                wdata = i_riscv_mw_wb.uimm;
            end
            riscv_isa_pkg::RES_CSR: begin
                wdata = i_riscv_mw_wb.csrout;
            end
            riscv_isa_pkg::RES_SC: begin
                wdata = i_riscv_mw_wb.rddata_sc;
            end
            default: begin
                wdata = '0;
            end
        endcase
    end

    // a trapping instruction must not update rd
    assign o_riscv_mw_rfw.we    = i_riscv_mw_wb.regw && !i_riscv_mw_wb.gototrap &&
                                  (i_riscv_mw_wb.rdaddr != '0);
    assign o_riscv_mw_rfw.waddr = i_riscv_mw_wb.rdaddr;
    assign o_riscv_mw_rfw.wdata = wdata;

endmodule

`default_nettype wire
